/* verilog/axi_xbar_config.svh */
`ifndef AXI_XBAR_CONFIG_SVH
`define AXI_XBAR_CONFIG_SVH

// Channel widths
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// Port counts, default slave included
`define AXI_MASTER_NUM 2
`define AXI_SLAVE_NUM  3

// S0 window 0x0000_0000 to 0x0000_FFFF
`define AXI_S0_BASE 32'h0000_0000
`define AXI_S0_MASK 32'hFFFF_0000

// S1 window 0x0001_0000 to 0x0001_FFFF
`define AXI_S1_BASE 32'h0001_0000
`define AXI_S1_MASK 32'hFFFF_0000

// Anything outside both windows goes to the default slave

`endif

/* verilog/axi_xbar_pkg.sv */
package axi_xbar_pkg;

    typedef enum logic {
        MST_1,
        MST_2
    } master_id_e;

    // SLV_DEF is the internal decode error slave
    typedef enum logic [1:0] {
        SLV_0,
        SLV_1,
        SLV_DEF
    } slave_id_e;

    // Write phases, address then data then response
    typedef enum logic [1:0] {
        AW_IDLE,
        AW_DATA,
        AW_RESP
    } aw_state_e;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } resp_e;

    typedef struct packed {
        master_id_e mst;
        slave_id_e  slv;
    } wr_route_t;

endpackage

/* verilog/axi_w_if.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

interface axi_w_if;
    logic [`AXI_DATA_BITS-1:0] data;
    logic [`AXI_STRB_BITS-1:0] strb;
    logic                      last;
    logic                      valid;
    logic                      ready;

    // Source side drives the beat
    modport src (output data, strb, last, valid, input ready);

    modport dst (input data, strb, last, valid, output ready);
endinterface

/* verilog/aw_ch.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module aw_ch import axi_xbar_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`AXI_ADDR_BITS-1:0] awaddr_m1_i,
    input  logic                      awvalid_m1_i,
    output logic                      awready_m1_o,
    input  logic [`AXI_ADDR_BITS-1:0] awaddr_m2_i,
    input  logic                      awvalid_m2_i,
    output logic                      awready_m2_o,
    output logic [`AXI_ADDR_BITS-1:0] awaddr_o,
    output logic                      awvalid_s0_o,
    output logic                      awvalid_s1_o,
    output logic                      awvalid_sd_o,
    input  logic                      awready_s0_i,
    input  logic                      awready_s1_i,
    input  logic                      awready_sd_i,
    input  logic                      data_done_i,
    input  logic                      resp_done_i,
    output wr_route_t                 route_o,
    output logic                      route_set_o
);
    aw_state_e  state;
    aw_state_e  state_nxt;
    master_id_e last_grant;
    master_id_e grant;
    master_id_e held_id;
    logic       held;
    slave_id_e  dec_slv;
    logic [`AXI_ADDR_BITS-1:0] addr_sel;
    logic       req_sel;
    logic       aw_active;
    logic       sel_ready;
    logic       aw_hs;
    wr_route_t  route_q;

    // Round robin, a pending request keeps its grant until the handshake
    always_comb begin
        if (held)
            grant = held_id;
        else if (awvalid_m1_i && awvalid_m2_i)
            grant = (last_grant == MST_1) ? MST_2 : MST_1;
        else if (awvalid_m2_i)
            grant = MST_2;
        else
            grant = MST_1;
    end

    assign addr_sel = (grant == MST_2) ? awaddr_m2_i : awaddr_m1_i;
    assign req_sel  = (grant == MST_2) ? awvalid_m2_i : awvalid_m1_i;
    assign awaddr_o = addr_sel;

    always_comb begin
        if ((addr_sel & `AXI_S0_MASK) == `AXI_S0_BASE)
            dec_slv = SLV_0;
        else if ((addr_sel & `AXI_S1_MASK) == `AXI_S1_BASE)
            dec_slv = SLV_1;
        else
            dec_slv = SLV_DEF;
    end

    always_comb begin
        case (dec_slv)
            SLV_0:   sel_ready = awready_s0_i;
            SLV_1:   sel_ready = awready_s1_i;
            default: sel_ready = awready_sd_i;
        endcase
    end

    assign aw_active = (state == AW_IDLE) && req_sel;
    assign aw_hs     = aw_active && sel_ready;

    assign awvalid_s0_o = aw_active && (dec_slv == SLV_0);
    assign awvalid_s1_o = aw_active && (dec_slv == SLV_1);
    assign awvalid_sd_o = aw_active && (dec_slv == SLV_DEF);
    assign awready_m1_o = aw_hs && (grant == MST_1);
    assign awready_m2_o = aw_hs && (grant == MST_2);

    // New route is visible in the handshake cycle so w_ch latches it on that edge
    assign route_set_o = aw_hs;
    assign route_o     = aw_hs ? '{mst: grant, slv: dec_slv} : route_q;

    always_comb begin
        state_nxt = state;
        case (state)
            AW_IDLE: if (aw_hs) state_nxt = AW_DATA;
            AW_DATA: if (data_done_i) state_nxt = AW_RESP;
            AW_RESP: if (resp_done_i) state_nxt = AW_IDLE;
            default: state_nxt = AW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= AW_IDLE;
            last_grant <= MST_2;
            held       <= 1'b0;
            held_id    <= MST_1;
            route_q    <= '{mst: MST_1, slv: SLV_0};
        end else begin
            state <= state_nxt;
            if (aw_hs) begin
                last_grant <= grant;
                route_q    <= '{mst: grant, slv: dec_slv};
                held       <= 1'b0;
            end else if (aw_active) begin
                held    <= 1'b1;
                held_id <= grant;
            end
        end
    end
endmodule

/* verilog/w_ch.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module w_ch import axi_xbar_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    axi_w_if.dst      m1_w,
    axi_w_if.dst      m2_w,
    axi_w_if.src      s0_w,
    axi_w_if.src      s1_w,
    axi_w_if.src      sd_w,
    input  wr_route_t route_i,
    input  logic      route_set_i,
    output logic      data_done_o
);
    wr_route_t                  route_q;
    logic                       busy;
    logic [`AXI_MASTER_NUM-1:0] m_valid;
    logic [`AXI_SLAVE_NUM-1:0]  s_ready;
    logic [`AXI_DATA_BITS-1:0]  m_data;
    logic [`AXI_STRB_BITS-1:0]  m_strb;
    logic                       m_last;
    logic                       beat_valid;
    logic                       beat_ready;

    assign m_valid = {m2_w.valid, m1_w.valid};
    assign s_ready = {sd_w.ready, s1_w.ready, s0_w.ready};

    // Beat of the granted master
    assign m_data = (route_q.mst == MST_2) ? m2_w.data : m1_w.data;
    assign m_strb = (route_q.mst == MST_2) ? m2_w.strb : m1_w.strb;
    assign m_last = (route_q.mst == MST_2) ? m2_w.last : m1_w.last;

    assign beat_valid = busy && m_valid[route_q.mst];
    assign beat_ready = busy && s_ready[route_q.slv];

    assign s0_w.data  = m_data;
    assign s0_w.strb  = m_strb;
    assign s0_w.last  = m_last;
    assign s0_w.valid = beat_valid && (route_q.slv == SLV_0);

    assign s1_w.data  = m_data;
    assign s1_w.strb  = m_strb;
    assign s1_w.last  = m_last;
    assign s1_w.valid = beat_valid && (route_q.slv == SLV_1);

    assign sd_w.data  = m_data;
    assign sd_w.strb  = m_strb;
    assign sd_w.last  = m_last;
    assign sd_w.valid = beat_valid && (route_q.slv == SLV_DEF);

    // Only the granted master sees a ready
    assign m1_w.ready = beat_ready && (route_q.mst == MST_1);
    assign m2_w.ready = beat_ready && (route_q.mst == MST_2);

    assign data_done_o = beat_valid && beat_ready && m_last;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy    <= 1'b0;
            route_q <= '{mst: MST_1, slv: SLV_0};
        end else if (route_set_i) begin
            busy    <= 1'b1;
            route_q <= route_i;
        end else if (data_done_o) begin
            busy <= 1'b0;
        end
    end
endmodule

/* verilog/b_ch.sv */
`timescale 1ns/1ps

module b_ch import axi_xbar_pkg::*; (
    input  logic [1:0] bresp_s0_i,
    input  logic       bvalid_s0_i,
    output logic       bready_s0_o,
    input  logic [1:0] bresp_s1_i,
    input  logic       bvalid_s1_i,
    output logic       bready_s1_o,
    input  logic [1:0] bresp_sd_i,
    input  logic       bvalid_sd_i,
    output logic       bready_sd_o,
    output logic [1:0] bresp_m1_o,
    output logic       bvalid_m1_o,
    input  logic       bready_m1_i,
    output logic [1:0] bresp_m2_o,
    output logic       bvalid_m2_o,
    input  logic       bready_m2_i,
    input  wr_route_t  route_i,
    output logic       resp_done_o
);
    logic [1:0] bresp_sel;
    logic       bvalid_sel;
    logic       bready_sel;

    always_comb begin
        case (route_i.slv)
            SLV_0: begin
                bresp_sel  = bresp_s0_i;
                bvalid_sel = bvalid_s0_i;
            end
            SLV_1: begin
                bresp_sel  = bresp_s1_i;
                bvalid_sel = bvalid_s1_i;
            end
            default: begin
                bresp_sel  = bresp_sd_i;
                bvalid_sel = bvalid_sd_i;
            end
        endcase
    end

    assign bready_sel = (route_i.mst == MST_2) ? bready_m2_i : bready_m1_i;

    assign bvalid_m1_o = bvalid_sel && (route_i.mst == MST_1);
    assign bvalid_m2_o = bvalid_sel && (route_i.mst == MST_2);
    assign bresp_m1_o  = (route_i.mst == MST_1) ? bresp_sel : RESP_OKAY;
    assign bresp_m2_o  = (route_i.mst == MST_2) ? bresp_sel : RESP_OKAY;

    // Ready goes back only to the slave that owns the write
    assign bready_s0_o = bready_sel && (route_i.slv == SLV_0);
    assign bready_s1_o = bready_sel && (route_i.slv == SLV_1);
    assign bready_sd_o = bready_sel && (route_i.slv == SLV_DEF);

    assign resp_done_o = bvalid_sel && bready_sel;
endmodule

/* verilog/default_slave.sv */
`timescale 1ns/1ps

module default_slave import axi_xbar_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       awvalid_i,
    output logic       awready_o,
    axi_w_if.dst       w,
    output logic [1:0] bresp_o,
    output logic       bvalid_o,
    input  logic       bready_i
);
    aw_state_e state;

    // Beats only matter for their last flag, data is dropped
    assign w.ready  = (state == AW_DATA);
    assign bvalid_o = (state == AW_RESP);
    assign bresp_o  = bvalid_o ? RESP_DECERR : RESP_OKAY;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= AW_IDLE;
            awready_o <= 1'b0;
        end else begin
            case (state)
                AW_IDLE: begin
                    // Ready one cycle after valid
                    if (awvalid_i && awready_o) begin
                        awready_o <= 1'b0;
                        state     <= AW_DATA;
                    end else begin
                        awready_o <= awvalid_i;
                    end
                end
                AW_DATA: begin
                    if (w.valid && w.last)
                        state <= AW_RESP;
                end
                AW_RESP: begin
                    if (bready_i)
                        state <= AW_IDLE;
                end
                default: state <= AW_IDLE;
            endcase
        end
    end
endmodule

/* verilog/axi_write_xbar.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module axi_write_xbar import axi_xbar_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // M1
    input  logic [`AXI_ADDR_BITS-1:0] awaddr_m1_i,
    input  logic                      awvalid_m1_i,
    output logic                      awready_m1_o,
    input  logic [`AXI_DATA_BITS-1:0] wdata_m1_i,
    input  logic [`AXI_STRB_BITS-1:0] wstrb_m1_i,
    input  logic                      wlast_m1_i,
    input  logic                      wvalid_m1_i,
    output logic                      wready_m1_o,
    output logic [1:0]                bresp_m1_o,
    output logic                      bvalid_m1_o,
    input  logic                      bready_m1_i,
    // M2
    input  logic [`AXI_ADDR_BITS-1:0] awaddr_m2_i,
    input  logic                      awvalid_m2_i,
    output logic                      awready_m2_o,
    input  logic [`AXI_DATA_BITS-1:0] wdata_m2_i,
    input  logic [`AXI_STRB_BITS-1:0] wstrb_m2_i,
    input  logic                      wlast_m2_i,
    input  logic                      wvalid_m2_i,
    output logic                      wready_m2_o,
    output logic [1:0]                bresp_m2_o,
    output logic                      bvalid_m2_o,
    input  logic                      bready_m2_i,
    // S0
    output logic [`AXI_ADDR_BITS-1:0] awaddr_s0_o,
    output logic                      awvalid_s0_o,
    input  logic                      awready_s0_i,
    output logic [`AXI_DATA_BITS-1:0] wdata_s0_o,
    output logic [`AXI_STRB_BITS-1:0] wstrb_s0_o,
    output logic                      wlast_s0_o,
    output logic                      wvalid_s0_o,
    input  logic                      wready_s0_i,
    input  logic [1:0]                bresp_s0_i,
    input  logic                      bvalid_s0_i,
    output logic                      bready_s0_o,
    // S1
    output logic [`AXI_ADDR_BITS-1:0] awaddr_s1_o,
    output logic                      awvalid_s1_o,
    input  logic                      awready_s1_i,
    output logic [`AXI_DATA_BITS-1:0] wdata_s1_o,
    output logic [`AXI_STRB_BITS-1:0] wstrb_s1_o,
    output logic                      wlast_s1_o,
    output logic                      wvalid_s1_o,
    input  logic                      wready_s1_i,
    input  logic [1:0]                bresp_s1_i,
    input  logic                      bvalid_s1_i,
    output logic                      bready_s1_o
);
    logic [`AXI_ADDR_BITS-1:0] awaddr;
    logic       awvalid_sd;
    logic       awready_sd;
    logic [1:0] bresp_sd;
    logic       bvalid_sd;
    logic       bready_sd;
    wr_route_t  route;
    logic       route_set;
    logic       data_done;
    logic       resp_done;

    axi_w_if m1_w ();
    axi_w_if m2_w ();
    axi_w_if s0_w ();
    axi_w_if s1_w ();
    axi_w_if sd_w ();

    // Master W ports into their bundles
    assign m1_w.data  = wdata_m1_i;
    assign m1_w.strb  = wstrb_m1_i;
    assign m1_w.last  = wlast_m1_i;
    assign m1_w.valid = wvalid_m1_i;
    assign wready_m1_o = m1_w.ready;

    assign m2_w.data  = wdata_m2_i;
    assign m2_w.strb  = wstrb_m2_i;
    assign m2_w.last  = wlast_m2_i;
    assign m2_w.valid = wvalid_m2_i;
    assign wready_m2_o = m2_w.ready;

    assign wdata_s0_o  = s0_w.data;
    assign wstrb_s0_o  = s0_w.strb;
    assign wlast_s0_o  = s0_w.last;
    assign wvalid_s0_o = s0_w.valid;
    assign s0_w.ready  = wready_s0_i;

    assign wdata_s1_o  = s1_w.data;
    assign wstrb_s1_o  = s1_w.strb;
    assign wlast_s1_o  = s1_w.last;
    assign wvalid_s1_o = s1_w.valid;
    assign s1_w.ready  = wready_s1_i;

    // One address bus, qualified per slave by awvalid
    assign awaddr_s0_o = awaddr;
    assign awaddr_s1_o = awaddr;

    aw_ch u_aw_ch (
        .clk          (clk),
        .rst          (rst),
        .awaddr_m1_i  (awaddr_m1_i),
        .awvalid_m1_i (awvalid_m1_i),
        .awready_m1_o (awready_m1_o),
        .awaddr_m2_i  (awaddr_m2_i),
        .awvalid_m2_i (awvalid_m2_i),
        .awready_m2_o (awready_m2_o),
        .awaddr_o     (awaddr),
        .awvalid_s0_o (awvalid_s0_o),
        .awvalid_s1_o (awvalid_s1_o),
        .awvalid_sd_o (awvalid_sd),
        .awready_s0_i (awready_s0_i),
        .awready_s1_i (awready_s1_i),
        .awready_sd_i (awready_sd),
        .data_done_i  (data_done),
        .resp_done_i  (resp_done),
        .route_o      (route),
        .route_set_o  (route_set)
    );

    w_ch u_w_ch (
        .clk         (clk),
        .rst         (rst),
        .m1_w        (m1_w),
        .m2_w        (m2_w),
        .s0_w        (s0_w),
        .s1_w        (s1_w),
        .sd_w        (sd_w),
        .route_i     (route),
        .route_set_i (route_set),
        .data_done_o (data_done)
    );

    b_ch u_b_ch (
        .bresp_s0_i  (bresp_s0_i),
        .bvalid_s0_i (bvalid_s0_i),
        .bready_s0_o (bready_s0_o),
        .bresp_s1_i  (bresp_s1_i),
        .bvalid_s1_i (bvalid_s1_i),
        .bready_s1_o (bready_s1_o),
        .bresp_sd_i  (bresp_sd),
        .bvalid_sd_i (bvalid_sd),
        .bready_sd_o (bready_sd),
        .bresp_m1_o  (bresp_m1_o),
        .bvalid_m1_o (bvalid_m1_o),
        .bready_m1_i (bready_m1_i),
        .bresp_m2_o  (bresp_m2_o),
        .bvalid_m2_o (bvalid_m2_o),
        .bready_m2_i (bready_m2_i),
        .route_i     (route),
        .resp_done_o (resp_done)
    );

    default_slave u_default_slave (
        .clk       (clk),
        .rst       (rst),
        .awvalid_i (awvalid_sd),
        .awready_o (awready_sd),
        .w         (sd_w),
        .bresp_o   (bresp_sd),
        .bvalid_o  (bvalid_sd),
        .bready_i  (bready_sd)
    );
endmodule

/* sim/xbar_checker.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module xbar_checker import axi_xbar_pkg::*; (
    input  logic                           clk,
    input  logic                           quiet_i,
    input  logic [1:0]                     awvalid_m_i,
    input  logic [1:0]                     awready_m_i,
    input  logic [1:0]                     wready_m_i,
    input  logic [1:0]                     bvalid_m_i,
    input  logic [1:0]                     bready_m_i,
    input  logic [1:0][1:0]                bresp_m_i,
    input  logic [1:0][`AXI_ADDR_BITS-1:0] awaddr_s_i,
    input  logic [1:0]                     awvalid_s_i,
    input  logic [1:0]                     awready_s_i,
    input  logic [1:0]                     wvalid_s_i,
    input  logic [1:0]                     wready_s_i,
    input  logic [1:0]                     wlast_s_i,
    input  logic [1:0][`AXI_DATA_BITS-1:0] wdata_s_i,
    input  logic [1:0][`AXI_STRB_BITS-1:0] wstrb_s_i,
    input  logic [1:0]                     bready_s_i
);
    typedef logic [`AXI_DATA_BITS+`AXI_STRB_BITS:0] beat_t;

    typedef struct packed {
        logic [`AXI_ADDR_BITS-1:0] addr;
        slave_id_e                 slv;
        resp_e                     resp;
        logic [2:0]                len;
    } hdr_t;

    // Writes queued per master
    // Beats move to a slave queue on the AW handshake
    hdr_t       hdr_q [2][$];
    beat_t      mst_q [2][$];
    beat_t      slv_q [2][$];
    resp_e      resp_exp [2];
    logic [1:0] resp_pend = 2'b00;
    logic       idle = 1'b1;
    logic       started = 1'b0;
    logic       both_req = 1'b0;
    int         last_mst = 1;
    int         cur_slv = int'(SLV_DEF);
    int         beat_errs;
    int         resp_errs;
    int         other_errs;

    task automatic expect_write(input int m, input logic [`AXI_ADDR_BITS-1:0] addr,
                                input slave_id_e slv, input resp_e resp, input int len);
        hdr_t h;
        h.addr = addr;
        h.slv  = slv;
        h.resp = resp;
        h.len  = 3'(len);
        hdr_q[m].push_back(h);
    endtask

    task automatic expect_beat(input int m, input logic [`AXI_DATA_BITS-1:0] data,
                               input logic [`AXI_STRB_BITS-1:0] strb, input logic last);
        mst_q[m].push_back({data, strb, last});
    endtask

    task automatic report_missing();
        for (int m = 0; m < 2; m++) begin
            if (resp_pend[m] || hdr_q[m].size() != 0) begin
                $display("Master M%0d never received the response to its write", m + 1);
                other_errs++;
            end
        end
    endtask

    // Handshakes at the next rising edge are settled by the falling edge
    always @(negedge clk) begin
        hdr_t                      h;
        beat_t                     b;
        logic [1:0]                aw_hs;
        logic [1:0]                exp_aw;
        logic [1:0]                exp_bready;
        logic [`AXI_ADDR_BITS-1:0] exp_addr;
        aw_hs    = awvalid_m_i & awready_m_i;
        exp_aw   = 2'b00;
        exp_addr = '0;
        if (quiet_i && |{awready_m_i, wready_m_i, bvalid_m_i, awvalid_s_i, wvalid_s_i,
                         bready_s_i}) begin
            other_errs++;
            $display("ERROR at %0d ns: DUT ready or valid high before any stimulus", $time);
        end
        if (idle && !started && |awvalid_m_i) begin
            started  = 1'b1;
            both_req = &awvalid_m_i;
        end
        for (int m = 0; m < 2; m++) begin
            if (aw_hs[m] && (!idle || hdr_q[m].size() == 0)) begin
                other_errs++;
                $display("ERROR at %0d ns: M%0d AW handshake while a write is open", $time, m + 1);
            end else if (aw_hs[m]) begin
                h = hdr_q[m].pop_front();
                if (both_req && m == last_mst) begin
                    other_errs++;
                    $display("ERROR at %0d ns: M%0d granted twice in a row", $time, m + 1);
                end
                if (h.slv != SLV_DEF)
                    exp_aw[int'(h.slv)] = 1'b1;
                repeat (h.len) begin
                    b = mst_q[m].pop_front();
                    if (h.slv != SLV_DEF)
                        slv_q[int'(h.slv)].push_back(b);
                end
                exp_addr     = h.addr;
                cur_slv      = int'(h.slv);
                resp_exp[m]  = h.resp;
                resp_pend[m] = 1'b1;
                last_mst     = m;
                idle         = 1'b0;
                started      = 1'b0;
                both_req     = 1'b0;
            end
        end
        if ((awvalid_s_i & awready_s_i) != exp_aw) begin
            other_errs++;
            $display("ERROR at %0d ns: slave AW handshake %b, expected %b", $time,
                     awvalid_s_i & awready_s_i, exp_aw);
        end
        for (int s = 0; s < 2; s++) begin
            if (exp_aw[s] && awaddr_s_i[s] != exp_addr) begin
                other_errs++;
                $display("ERROR at %0d ns: S%0d address %h, expected %h", $time, s,
                         awaddr_s_i[s], exp_addr);
            end
        end
        for (int s = 0; s < 2; s++) begin
            if (wvalid_s_i[s] && slv_q[s].size() == 0) begin
                beat_errs++;
                $display("ERROR at %0d ns: W valid at S%0d with no beat expected", $time, s);
            end else if (wvalid_s_i[s] && wready_s_i[s]) begin
                b = slv_q[s].pop_front();
                if (b != {wdata_s_i[s], wstrb_s_i[s], wlast_s_i[s]}) begin
                    beat_errs++;
                    $display("ERROR at %0d ns: S%0d beat %h, expected %h", $time, s,
                             {wdata_s_i[s], wstrb_s_i[s], wlast_s_i[s]}, b);
                end
            end
        end
        // B ready reaches only the slave of the open write
        exp_bready = 2'b00;
        for (int s = 0; s < 2; s++)
            exp_bready[s] = !idle && cur_slv == s && bready_m_i[last_mst];
        if (bready_s_i != exp_bready) begin
            other_errs++;
            $display("ERROR at %0d ns: slave B ready %b, expected %b", $time,
                     bready_s_i, exp_bready);
        end
        for (int m = 0; m < 2; m++) begin
            if ((bvalid_m_i[m] || wready_m_i[m]) && !resp_pend[m]) begin
                other_errs++;
                $display("ERROR at %0d ns: M%0d sees W ready or B valid with no write",
                         $time, m + 1);
            end else if (bvalid_m_i[m] && bready_m_i[m]) begin
                if (bresp_m_i[m] != resp_exp[m]) begin
                    resp_errs++;
                    $display("ERROR at %0d ns: M%0d response %0d, expected %0d", $time,
                             m + 1, bresp_m_i[m], resp_exp[m]);
                end
                resp_pend[m] = 1'b0;
                idle         = 1'b1;
            end
        end
    end
endmodule

/* sim/tb_axi_write_xbar.sv */
`timescale 1ns/1ps
`include "axi_xbar_config.svh"

module tb_axi_write_xbar import axi_xbar_pkg::*; ();
    // Writes per master
    localparam int N_WRITES    = 12;
    localparam int CYCLE_LIMIT = 40 * 2 * N_WRITES + 200;

    logic                           clk;
    logic                           rst;
    logic                           quiet;
    logic [1:0][`AXI_ADDR_BITS-1:0] awaddr_m;
    logic [1:0]                     awvalid_m;
    logic [1:0]                     awready_m;
    logic [1:0][`AXI_DATA_BITS-1:0] wdata_m;
    logic [1:0][`AXI_STRB_BITS-1:0] wstrb_m;
    logic [1:0]                     wlast_m;
    logic [1:0]                     wvalid_m;
    logic [1:0]                     wready_m;
    logic [1:0][1:0]                bresp_m;
    logic [1:0]                     bvalid_m;
    logic [1:0]                     bready_m;
    logic [1:0][`AXI_ADDR_BITS-1:0] awaddr_s;
    logic [1:0]                     awvalid_s;
    logic [1:0]                     awready_s;
    logic [1:0][`AXI_DATA_BITS-1:0] wdata_s;
    logic [1:0][`AXI_STRB_BITS-1:0] wstrb_s;
    logic [1:0]                     wlast_s;
    logic [1:0]                     wvalid_s;
    logic [1:0]                     wready_s;
    logic [1:0][1:0]                bresp_s;
    logic [1:0]                     bvalid_s;
    logic [1:0]                     bready_s;
    int                             cycles;

    axi_write_xbar UUT (
        .clk          (clk),
        .rst          (rst),
        .awaddr_m1_i  (awaddr_m[0]),
        .awvalid_m1_i (awvalid_m[0]),
        .awready_m1_o (awready_m[0]),
        .wdata_m1_i   (wdata_m[0]),
        .wstrb_m1_i   (wstrb_m[0]),
        .wlast_m1_i   (wlast_m[0]),
        .wvalid_m1_i  (wvalid_m[0]),
        .wready_m1_o  (wready_m[0]),
        .bresp_m1_o   (bresp_m[0]),
        .bvalid_m1_o  (bvalid_m[0]),
        .bready_m1_i  (bready_m[0]),
        .awaddr_m2_i  (awaddr_m[1]),
        .awvalid_m2_i (awvalid_m[1]),
        .awready_m2_o (awready_m[1]),
        .wdata_m2_i   (wdata_m[1]),
        .wstrb_m2_i   (wstrb_m[1]),
        .wlast_m2_i   (wlast_m[1]),
        .wvalid_m2_i  (wvalid_m[1]),
        .wready_m2_o  (wready_m[1]),
        .bresp_m2_o   (bresp_m[1]),
        .bvalid_m2_o  (bvalid_m[1]),
        .bready_m2_i  (bready_m[1]),
        .awaddr_s0_o  (awaddr_s[0]),
        .awvalid_s0_o (awvalid_s[0]),
        .awready_s0_i (awready_s[0]),
        .wdata_s0_o   (wdata_s[0]),
        .wstrb_s0_o   (wstrb_s[0]),
        .wlast_s0_o   (wlast_s[0]),
        .wvalid_s0_o  (wvalid_s[0]),
        .wready_s0_i  (wready_s[0]),
        .bresp_s0_i   (bresp_s[0]),
        .bvalid_s0_i  (bvalid_s[0]),
        .bready_s0_o  (bready_s[0]),
        .awaddr_s1_o  (awaddr_s[1]),
        .awvalid_s1_o (awvalid_s[1]),
        .awready_s1_i (awready_s[1]),
        .wdata_s1_o   (wdata_s[1]),
        .wstrb_s1_o   (wstrb_s[1]),
        .wlast_s1_o   (wlast_s[1]),
        .wvalid_s1_o  (wvalid_s[1]),
        .wready_s1_i  (wready_s[1]),
        .bresp_s1_i   (bresp_s[1]),
        .bvalid_s1_i  (bvalid_s[1]),
        .bready_s1_o  (bready_s[1])
    );

    xbar_checker u_checker (
        .clk         (clk),
        .quiet_i     (quiet),
        .awvalid_m_i (awvalid_m),
        .awready_m_i (awready_m),
        .wready_m_i  (wready_m),
        .bvalid_m_i  (bvalid_m),
        .bready_m_i  (bready_m),
        .bresp_m_i   (bresp_m),
        .awaddr_s_i  (awaddr_s),
        .awvalid_s_i (awvalid_s),
        .awready_s_i (awready_s),
        .wvalid_s_i  (wvalid_s),
        .wready_s_i  (wready_s),
        .wlast_s_i   (wlast_s),
        .wdata_s_i   (wdata_s),
        .wstrb_s_i   (wstrb_s),
        .bready_s_i  (bready_s)
    );

    // Window test by offset from the base
    // Anything else is a decode error
    function automatic slave_id_e expected_route(input logic [`AXI_ADDR_BITS-1:0] addr,
                                                 output resp_e resp);
        resp = RESP_OKAY;
        if ((addr - `AXI_S0_BASE) <= ~`AXI_S0_MASK)
            return SLV_0;
        if ((addr - `AXI_S1_BASE) <= ~`AXI_S1_MASK)
            return SLV_1;
        resp = RESP_DECERR;
        return SLV_DEF;
    endfunction

    task automatic run_master(input int m);
        logic [`AXI_ADDR_BITS-1:0] addr;
        logic [`AXI_DATA_BITS-1:0] data [4];
        logic [`AXI_STRB_BITS-1:0] strb [4];
        slave_id_e                 slv;
        resp_e                     resp;
        int                        len;
        for (int n = 0; n < N_WRITES; n++) begin
            addr = $urandom % 32'h0001_0000;
            case ($urandom % 3)
                0: addr = addr | `AXI_S0_BASE;
                1: addr = addr | `AXI_S1_BASE;
                // Just past the S1 window
                default: addr = addr | 32'h0002_0000;
            endcase
            len = 1 + int'($urandom % 4);
            slv = expected_route(addr, resp);
            u_checker.expect_write(m, addr, slv, resp, len);
            for (int i = 0; i < len; i++) begin
                data[i] = $urandom;
                strb[i] = 4'($urandom);
                u_checker.expect_beat(m, data[i], strb[i], i == len - 1);
            end
            repeat ($urandom % 3) begin
                @(posedge clk);
                #1;
            end
            awaddr_m[m]  = addr;
            awvalid_m[m] = 1'b1;
            do @(negedge clk); while (!awready_m[m]);
            @(posedge clk);
            #1;
            awvalid_m[m] = 1'b0;
            for (int i = 0; i < len; i++) begin
                wdata_m[m]  = data[i];
                wstrb_m[m]  = strb[i];
                wlast_m[m]  = (i == len - 1);
                wvalid_m[m] = 1'b1;
                do @(negedge clk); while (!wready_m[m]);
                @(posedge clk);
                #1;
            end
            wvalid_m[m] = 1'b0;
            wlast_m[m]  = 1'b0;
            repeat ($urandom % 2) begin
                @(posedge clk);
                #1;
            end
            bready_m[m] = 1'b1;
            do @(negedge clk); while (!bvalid_m[m]);
            @(posedge clk);
            #1;
            bready_m[m] = 1'b0;
        end
    endtask

    // Random stalls and an OKAY response after the last beat
    task automatic run_slave(input int s);
        logic last_hs;
        logic b_hs;
        forever begin
            @(negedge clk);
            last_hs = wvalid_s[s] && wready_s[s] && wlast_s[s];
            b_hs    = bvalid_s[s] && bready_s[s];
            @(posedge clk);
            #1;
            awready_s[s] = ($urandom % 3) != 0;
            wready_s[s]  = ($urandom % 3) != 0;
            if (b_hs)
                bvalid_s[s] = 1'b0;
            if (last_hs) begin
                bvalid_s[s] = 1'b1;
                bresp_s[s]  = RESP_OKAY;
            end
        end
    endtask

    task automatic print_summary(output int total);
        total = u_checker.beat_errs + u_checker.resp_errs + u_checker.other_errs;
        $display("Errors: %0d beat, %0d response, %0d other", u_checker.beat_errs,
                 u_checker.resp_errs, u_checker.other_errs);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial run_slave(0);
    initial run_slave(1);

    initial begin
        int total;
        void'($urandom(4053));
        rst       = 1'b0;
        quiet     = 1'b1;
        awaddr_m  = '0;
        awvalid_m = '0;
        wdata_m   = '0;
        wstrb_m   = '0;
        wlast_m   = '0;
        wvalid_m  = '0;
        bready_m  = '0;
        awready_s = '0;
        wready_s  = '0;
        bresp_s   = '0;
        bvalid_s  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        // Idle window with no stimulus
        repeat (20) @(posedge clk);
        #1;
        quiet = 1'b0;
        fork
            run_master(0);
            run_master(1);
        join
        repeat (10) @(posedge clk);
        u_checker.report_missing();
        print_summary(total);
        if (total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial begin
        int total;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the writes did not finish within %0d cycles", CYCLE_LIMIT);
        u_checker.report_missing();
        print_summary(total);
        $display("test failed");
        $finish;
    end
endmodule

/* sources.f */
+incdir+verilog
verilog/axi_xbar_pkg.sv
verilog/axi_w_if.sv
verilog/aw_ch.sv
verilog/w_ch.sv
verilog/b_ch.sv
verilog/default_slave.sv
verilog/axi_write_xbar.sv
sim/xbar_checker.sv
sim/tb_axi_write_xbar.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
TOP       := tb_axi_write_xbar
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := test passed

SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
